// File: Bender.yml
package:
  name: pow_accel

export_include_dirs:
  - common

sources:
  # RTL in compile order
  - include_dirs:
      - common
    files:
      - common/pow_pkg.sv
      - pow_pipe/pow_stage.sv
      - pow_pipe/pow_pipe.sv
      - hw/result_bank.sv
      - hw/pow_apb_ctrl.sv
      - hw/pow_top.sv

  # testbench, top module pow_tb
  - target: test
    include_dirs:
      - common
    files:
      - verification/pow_tb.sv

// File: common/pow_defines.svh
`ifndef POW_DEFINES_SVH
`define POW_DEFINES_SVH

////////////////////
// widths

`define POW_W  8                        // argument and power width.
`define POW_AW 8                        // apb address width.

////////////////////
// register offsets

`define POW_ADDR_ARG    8'h00           // write launches, read returns last argument.
`define POW_ADDR_STATUS 8'h04           // done bits in [3:0].
`define POW_ADDR_RES2   8'h08
`define POW_ADDR_RES3   8'h0C
`define POW_ADDR_RES4   8'h10
`define POW_ADDR_RES5   8'h14
`define POW_ADDR_COUNT  8'h18           // write of any value clears.

`endif

// File: common/pow_pkg.sv
`default_nettype none

`include "pow_defines.svh"

package pow_pkg;

    typedef logic [`POW_W-1:0]  pow_word_t;     // an argument or one power.
    typedef logic [15:0]        pow_cnt_t;      // completed x^5 results.
    typedef logic [`POW_AW-1:0] apb_addr_t;
    typedef logic [31:0]        apb_data_t;

    ////////////////////
    // apb

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    ////////////////////
    // datapath

    typedef struct packed {
        logic      vld;
        pow_word_t arg;                         // argument travelling with its product.
        pow_word_t prod;                        // partial power so far.
    } pow_stage_t;

    typedef struct packed {
        logic [3:0] vld;                        // bit 0 is x^2, bit 3 is x^5.
        pow_word_t  p2;
        pow_word_t  p3;
        pow_word_t  p4;
        pow_word_t  p5;
    } pow_res_t;

endpackage

`default_nettype wire

// File: filelist.f
+incdir+common
common/pow_pkg.sv
pow_pipe/pow_stage.sv
pow_pipe/pow_pipe.sv
hw/result_bank.sv
hw/pow_apb_ctrl.sv
hw/pow_top.sv
verification/pow_tb.sv

// File: hw/pow_apb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pow_defines.svh"

module pow_apb_ctrl (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire pow_pkg::apb_req_t  req,
    output pow_pkg::apb_rsp_t       rsp,
    output logic                    launch,
    output pow_pkg::pow_word_t      launch_arg,
    output logic                    clear,
    input  wire pow_pkg::pow_res_t  stored,
    input  wire logic [3:0]         done,
    input  wire pow_pkg::pow_cnt_t  count
);

    import pow_pkg::*;

    logic      access;                          // access phase, completes this cycle.
    logic      arg_wr;
    logic      cnt_wr;
    logic      mapped;                          // address hits the register map.
    apb_data_t rdata;

    ////////////////////
    // write decode

    assign access = req.psel & req.penable;
    assign arg_wr = access & req.pwrite & (req.paddr == `POW_ADDR_ARG);
    assign cnt_wr = access & req.pwrite & (req.paddr == `POW_ADDR_COUNT);

    // pulses land on the cycle after the access phase.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            launch <= 1'b0;
            clear  <= 1'b0;
        end else begin
            launch <= arg_wr;
            clear  <= cnt_wr;
        end
    end

    // also the value returned on arg reads.
    always_ff @(posedge clk) begin
        if (arg_wr) begin
            launch_arg <= req.pwdata[`POW_W-1:0];
        end
    end

    ////////////////////
    // read mux

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (req.paddr)
            `POW_ADDR_ARG: begin
                rdata = apb_data_t'(launch_arg);
            end
            `POW_ADDR_STATUS: begin
                rdata = apb_data_t'(done);      // done bits in [3:0].
            end
            `POW_ADDR_RES2: begin
                rdata = apb_data_t'(stored.p2);
            end
            `POW_ADDR_RES3: begin
                rdata = apb_data_t'(stored.p3);
            end
            `POW_ADDR_RES4: begin
                rdata = apb_data_t'(stored.p4);
            end
            `POW_ADDR_RES5: begin
                rdata = apb_data_t'(stored.p5);
            end
            `POW_ADDR_COUNT: begin
                rdata = apb_data_t'(count);
            end
            default: begin
                mapped = 1'b0;                  // unmapped, reads as zero.
            end
        endcase
    end

    // zero wait states, so pready is tied high.
    assign rsp = '{prdata: rdata, pready: 1'b1, pslverr: access & ~mapped};

endmodule

`default_nettype wire

// File: hw/pow_top.sv
`timescale 1ns/1ps
`default_nettype none

module pow_top (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire pow_pkg::apb_req_t apb_req,
    output pow_pkg::apb_rsp_t      apb_rsp
);

    import pow_pkg::*;

    logic       launch;                         // one-cycle argument launch.
    pow_word_t  launch_arg;
    logic       clear;                          // count clear pulse.
    pow_res_t   res;                            // pipeline outputs.
    pow_res_t   stored;                         // latest captured powers.
    logic [3:0] done;
    pow_cnt_t   count;

    ////////////////////
    // control

    pow_apb_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (apb_req),
        .rsp        (apb_rsp),
        .launch     (launch),
        .launch_arg (launch_arg),
        .clear      (clear),
        .stored     (stored),
        .done       (done),
        .count      (count)
    );

    ////////////////////
    // datapath

    pow_pipe u_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .launch     (launch),
        .launch_arg (launch_arg),
        .res        (res)
    );

    result_bank u_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .res        (res),
        .launch     (launch),
        .clear      (clear),
        .stored     (stored),
        .done       (done),
        .count      (count)
    );

endmodule

`default_nettype wire

// File: hw/result_bank.sv
`timescale 1ns/1ps
`default_nettype none

module result_bank (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire pow_pkg::pow_res_t res,
    input  wire logic              launch,
    input  wire logic              clear,
    output pow_pkg::pow_res_t      stored,
    output logic [3:0]             done,
    output pow_pkg::pow_cnt_t      count
);

    import pow_pkg::*;

    logic [3:0] done_q;
    pow_cnt_t   count_q;
    pow_word_t  p2_q;
    pow_word_t  p3_q;
    pow_word_t  p4_q;
    pow_word_t  p5_q;

    ////////////////////
    // status and count

    // a new launch drops the done bits, a capture in the same cycle sets its bit again.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 4'b0000;
        end else begin
            done_q <= (done_q & ~{4{launch}}) | res.vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= '0;
        end else if (res.vld[3]) begin
            count_q <= pow_cnt_t'(count_q + 1'b1);  // wraps at the counter width.
        end
    end

    ////////////////////
    // result capture

    always_ff @(posedge clk) begin
        if (res.vld[0]) begin
            p2_q <= res.p2;
        end
        if (res.vld[1]) begin
            p3_q <= res.p3;
        end
        if (res.vld[2]) begin
            p4_q <= res.p4;
        end
        if (res.vld[3]) begin
            p5_q <= res.p5;
        end
    end

    assign stored = '{vld: done_q, p2: p2_q, p3: p3_q, p4: p4_q, p5: p5_q};
    assign done   = done_q;
    assign count  = count_q;

endmodule

`default_nettype wire

// File: pow_pipe/pow_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module pow_pipe (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               launch,
    input  wire pow_pkg::pow_word_t launch_arg,
    output pow_pkg::pow_res_t       res
);

    import pow_pkg::*;

    logic       arg_vld_q;                      // argument register, one cycle after launch.
    pow_word_t  arg_q;
    pow_stage_t stg [0:4];                      // stg[n] is the output of stage n.

    ////////////////////
    // input register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arg_vld_q <= 1'b0;
        end else begin
            arg_vld_q <= launch;
        end
    end

    always_ff @(posedge clk) begin
        arg_q <= launch_arg;
    end

    // the argument is also the first partial product, so stage 1 forms x^2.
    assign stg[0] = '{vld: arg_vld_q, arg: arg_q, prod: arg_q};

    ////////////////////
    // multiplier stages

    for (genvar i = 0; i < 4; i++) begin : g_stage
        pow_stage u_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .in    (stg[i]),
            .out   (stg[i+1])
        );
    end

    ////////////////////
    // outputs

    assign res.vld = {stg[4].vld, stg[3].vld, stg[2].vld, stg[1].vld};
    assign res.p2  = stg[1].prod;               // x^2, two cycles after launch.
    assign res.p3  = stg[2].prod;
    assign res.p4  = stg[3].prod;
    assign res.p5  = stg[4].prod;               // x^5, five cycles after launch.

endmodule

`default_nettype wire

// File: pow_pipe/pow_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pow_stage (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire pow_pkg::pow_stage_t in,
    output pow_pkg::pow_stage_t      out
);

    import pow_pkg::*;

    pow_word_t mul;                             // next power, truncated to the word.
    logic      vld_q;
    pow_word_t arg_q;
    pow_word_t prod_q;

    assign mul = pow_word_t'(in.prod * in.arg);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= in.vld;
        end
    end

    // data follows the valid without a reset.
    always_ff @(posedge clk) begin
        arg_q  <= in.arg;
        prod_q <= mul;
    end

    assign out = '{vld: vld_q, arg: arg_q, prod: prod_q};

endmodule

`default_nettype wire

// File: verification/pow_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pow_defines.svh"

module pow_tb;

    import pow_pkg::*;

    localparam int PERIOD          = 40;
    localparam int DRIVE_DELAY     = 5;        // inputs change after the rising edge.
    localparam int SAMPLE_DELAY    = 30;       // outputs sampled before the next edge.
    localparam int RESET_CYCLES    = 8;
    localparam int RESULT_WAIT     = 8;        // write to all four powers readable.
    localparam int N_TESTS         = 6;
    localparam int MAX_TEST_CYCLES = 150;
    localparam int TIMEOUT_NS      = 2 * N_TESTS * MAX_TEST_CYCLES * PERIOD;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    int       errors;
    int       checks;

    pow_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    ////////////////////
    // clock and watchdog

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests completed, %0d errors so far", errors);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////
    // helpers

    // reference power, truncated to the data width.
    function automatic pow_word_t power_mod(input pow_word_t x, input int n);
        int acc;
        acc = 1;
        for (int i = 0; i < n; i++) begin
            acc = (acc * x) % (1 << `POW_W);
        end
        return pow_word_t'(acc);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // setup then access phase, starting and ending at a drive point.
    task automatic bus_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic slverr);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #(DRIVE_DELAY);
        apb_req.penable = 1'b1;
        #(SAMPLE_DELAY);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check("pready", apb_rsp.pready, 1'b1);
        @(posedge clk);
        #(DRIVE_DELAY);
        apb_req = '0;                          // idle unless the next transfer follows.
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic slverr);
        apb_data_t unused;
        bus_transfer(1'b1, addr, wdata, unused, slverr);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic slverr);
        bus_transfer(1'b0, addr, '0, rdata, slverr);
    endtask

    task automatic write_and_check(input apb_addr_t addr, input apb_data_t wdata);
        logic err;
        apb_write(addr, wdata, err);
        check($sformatf("pslverr wr 0x%02h", addr), err, 1'b0);
    endtask

    task automatic read_and_check(input apb_addr_t addr, input string name,
                                  input apb_data_t exp);
        apb_data_t rd;
        logic      err;
        apb_read(addr, rd, err);
        check(name, rd, exp);
        check($sformatf("pslverr rd 0x%02h", addr), err, 1'b0);
    endtask

    task automatic check_powers(input pow_word_t x);
        read_and_check(`POW_ADDR_RES2, "res2", apb_data_t'(power_mod(x, 2)));
        read_and_check(`POW_ADDR_RES3, "res3", apb_data_t'(power_mod(x, 3)));
        read_and_check(`POW_ADDR_RES4, "res4", apb_data_t'(power_mod(x, 4)));
        read_and_check(`POW_ADDR_RES5, "res5", apb_data_t'(power_mod(x, 5)));
    endtask

    task automatic launch_and_check(input pow_word_t x);
        write_and_check(`POW_ADDR_ARG, apb_data_t'(x));
        wait_cycles(RESULT_WAIT);
        read_and_check(`POW_ADDR_STATUS, "status", 32'h0000_000F);
        check_powers(x);
    endtask

    ////////////////////
    // directed tests

    task automatic test_reset_state();
        read_and_check(`POW_ADDR_STATUS, "status", 32'h0);
        read_and_check(`POW_ADDR_COUNT, "count", 32'h0);
    endtask

    task automatic test_single_arg();
        pow_word_t x;
        x = pow_word_t'($urandom);
        launch_and_check(x);
        read_and_check(`POW_ADDR_ARG, "arg", apb_data_t'(x));
    endtask

    task automatic test_edge_values();
        pow_word_t edge_vals [3];
        edge_vals[0] = '0;
        edge_vals[1] = pow_word_t'(1);
        edge_vals[2] = '1;                     // largest argument wraps hardest.
        for (int i = 0; i < 3; i++) begin
            launch_and_check(edge_vals[i]);
        end
    endtask

    task automatic test_back_to_back();
        apb_data_t cnt_before;
        pow_word_t x;
        logic      err;
        apb_read(`POW_ADDR_COUNT, cnt_before, err);
        x = '0;
        for (int i = 0; i < 5; i++) begin
            x = pow_word_t'($urandom);
            write_and_check(`POW_ADDR_ARG, apb_data_t'(x));  // several in flight.
        end
        wait_cycles(RESULT_WAIT);
        read_and_check(`POW_ADDR_STATUS, "status", 32'h0000_000F);
        check_powers(x);
        read_and_check(`POW_ADDR_COUNT, "count", (cnt_before + 32'd5) & 32'h0000_FFFF);
    endtask

    task automatic test_count_and_errors();
        apb_addr_t regs [7];
        apb_data_t snap [7];
        apb_data_t rd;
        logic      err;
        regs = '{`POW_ADDR_ARG, `POW_ADDR_STATUS, `POW_ADDR_RES2, `POW_ADDR_RES3,
                 `POW_ADDR_RES4, `POW_ADDR_RES5, `POW_ADDR_COUNT};
        apb_read(8'h1C, rd, err);
        check("pslverr rd 0x1c", err, 1'b1);
        check("prdata rd 0x1c", rd, 32'h0);
        apb_read(8'hFC, rd, err);
        check("pslverr rd 0xfc", err, 1'b1);
        check("prdata rd 0xfc", rd, 32'h0);
        // count is still nonzero here, so a stray clear would show.
        for (int i = 0; i < 7; i++) begin
            apb_read(regs[i], snap[i], err);
        end
        apb_write(8'h1C, 32'h0000_00A5, err);
        check("pslverr wr 0x1c", err, 1'b1);
        wait_cycles(RESULT_WAIT);
        for (int i = 0; i < 7; i++) begin
            read_and_check(regs[i], $sformatf("reg 0x%02h", regs[i]), snap[i]);
        end
        write_and_check(`POW_ADDR_COUNT, $urandom);
        read_and_check(`POW_ADDR_COUNT, "count", 32'h0);
    endtask

    task automatic test_done_clear();
        pow_word_t x;
        x = pow_word_t'($urandom);
        write_and_check(`POW_ADDR_ARG, apb_data_t'(x));
        read_and_check(`POW_ADDR_STATUS, "status after launch", 32'h0);
        wait_cycles(RESULT_WAIT);
        read_and_check(`POW_ADDR_STATUS, "status", 32'h0000_000F);
        check_powers(x);
    endtask

    ////////////////////
    // main sequence

    initial begin
        void'($urandom(97305));
        errors  = 0;
        checks  = 0;
        rst_n   = 1'b0;
        apb_req = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        wait_cycles(1);

        test_reset_state();
        test_single_arg();
        test_edge_values();
        test_back_to_back();
        test_count_and_errors();
        test_done_clear();
        wait_cycles(2);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
